/* list.f */
+incdir+source
+incdir+verification
source/vec_pkg.sv
source/vec_decoder.sv
source/vec_controller.sv
source/vec_unit.sv
source/vec_top.sv
verification/tb_vec_top.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the vector slice testbench with Verilator, runs it
# and fails when the log reports an error
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vec_top -f list.f -o tb_vec_top

./obj_dir/tb_vec_top 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
exit 0

/* verification/vec_model.svh */
//////////////////////////////////////////////////
// Reference model of the vector slice. Included in
// the testbench module, it predicts each response
// and result in the order the offers are taken
//////////////////////////////////////////////////

`ifndef VEC_MODEL_SVH
`define VEC_MODEL_SVH

`include "vec_defs.svh"

localparam int unsigned VRF_BYTES = `VEC_VLENB * `VEC_NRVREG;

// Architectural state
logic [7:0]  m_vrf [VRF_BYTES];
int unsigned m_vl;
int unsigned m_vstart;
logic        m_vill;
logic [1:0]  m_sew;
logic [2:0]  m_lmul;

// Expected {id, accept, writeback} and {id, rd, data}
logic [5:0]  exp_resp [$];
logic [40:0] exp_res [$];

function automatic bit vtype_legal(input logic [1:0] sew, input logic [2:0] lmul);
  int unsigned sew_bits;
  sew_bits = 8 << sew;
  if (sew == SEW_RES || lmul == LMUL_RES || lmul == LMUL_F8) begin
    return 1'b0;
  end
  // A fraction caps SEW at ELEN times that fraction
  if (lmul == LMUL_F2) begin
    return sew_bits <= `VEC_ELEN / 2;
  end
  if (lmul == LMUL_F4) begin
    return sew_bits <= `VEC_ELEN / 4;
  end
  return 1'b1;
endfunction

function automatic int unsigned vlmax_of(input logic [1:0] sew, input logic [2:0] lmul);
  int unsigned n;
  n = `VEC_VLENB >> sew;
  if (lmul == LMUL_F2) begin
    n = n >> 1;
  end else if (lmul == LMUL_F4) begin
    n = n >> 2;
  end else if (!lmul[2]) begin
    n = n << lmul;
  end
  return n;
endfunction

// log2(SEW/8) minus log2(LMUL)
function automatic int ratio_of(input logic [1:0] sew, input logic [2:0] lmul);
  return int'(sew) - (lmul[2] ? int'(lmul) - 8 : int'(lmul));
endfunction

// Groups wrap at the end of the register file
function automatic int unsigned byte_addr(input int unsigned vreg, input int unsigned idx,
                                          input int unsigned b);
  return (vreg * `VEC_VLENB + (idx << m_sew) + b) % VRF_BYTES;
endfunction

function automatic logic [31:0] read_elem(input int unsigned vreg, input int unsigned idx);
  logic [31:0] e;
  e = '0;
  for (int unsigned b = 0; b < (1 << m_sew); b++) begin
    e[8*b +: 8] = m_vrf[byte_addr(vreg, idx, b)];
  end
  return e;
endfunction

task automatic write_elem(input int unsigned vreg, input int unsigned idx,
                          input logic [31:0] val);
  for (int unsigned b = 0; b < (1 << m_sew); b++) begin
    m_vrf[byte_addr(vreg, idx, b)] = val[8*b +: 8];
  end
endtask

function automatic logic [31:0] sign_ext(input logic [31:0] e);
  case (m_sew)
    SEW_8:   return {{24{e[7]}}, e[7:0]};
    SEW_16:  return {{16{e[15]}}, e[15:0]};
    default: return e;
  endcase
endfunction

task automatic model_reset();
  foreach (m_vrf[i]) begin
    m_vrf[i] = '0;
  end
  m_vl     = 0;
  m_vstart = 0;
  m_vill   = 1'b1;
  m_sew    = SEW_8;
  m_lmul   = LMUL_1;
endtask

task automatic set_vill();
  m_vill = 1'b1;
  m_sew  = SEW_8;
  m_lmul = LMUL_1;
  m_vl   = 0;
endtask

task automatic model_take(input logic [31:0] instr, input logic [31:0] rs1,
                          input logic [3:0] id);
  logic [3:0]  op;
  logic [4:0]  rd, vs1, vs2;
  logic [1:0]  nsew;
  logic [2:0]  nlmul;
  logic        illegal, vfu, accept, wb, keep;
  logic [31:0] data;
  int unsigned vlmax, i;
  op      = instr[31:28];
  rd      = instr[11:7];
  vs1     = instr[19:15];
  vs2     = instr[24:20];
  nsew    = instr[24:23];
  nlmul   = instr[22:20];
  data    = '0;
  keep    = (vs1 == 0) && (rd == 0);
  vfu     = (op >= OP_VADD_VV) && (op <= OP_VMV_XS);
  illegal = (instr[6:0] != `VEC_MAJOR) || (op > OP_VMV_XS);
  // Vector register fields the op uses
  case (op)
    OP_VADD_VV: illegal |= (rd >= `VEC_NRVREG) || (vs1 >= `VEC_NRVREG) || (vs2 >= `VEC_NRVREG);
    OP_VADD_VX: illegal |= (rd >= `VEC_NRVREG) || (vs2 >= `VEC_NRVREG);
    OP_VMV_VX:  illegal |= rd >= `VEC_NRVREG;
    OP_VMV_XS:  illegal |= vs2 >= `VEC_NRVREG;
    default: ;
  endcase
  accept = !illegal && !(vfu && m_vill);
  wb     = accept && (op == OP_VSETVL || op == OP_CSRR || op == OP_VMV_XS);
  exp_resp.push_back({id, accept, wb});
  if (accept) begin
    case (op)
      OP_VSETVL: begin
        vlmax = vlmax_of(nsew, nlmul);
        if (!vtype_legal(nsew, nlmul) ||
            (keep && ratio_of(nsew, nlmul) != ratio_of(m_sew, m_lmul))) begin
          set_vill();
        end else begin
          if (!keep) begin
            m_vl = (vs1 == 0) ? vlmax : ((rs1 < vlmax) ? rs1 : vlmax);
          end
          m_vill = 1'b0;
          m_sew  = nsew;
          m_lmul = nlmul;
        end
        data = m_vl;
      end
      OP_CSRR: begin
        case (instr[27:26])
          CSR_VSTART: data = m_vstart;
          CSR_VL:     data = m_vl;
          CSR_VTYPE:  data = {m_vill, m_sew, m_lmul};
          default:    data = `VEC_VLENB;
        endcase
      end
      // vstart is an 8-bit CSR
      OP_CSRW_VSTART: m_vstart = rs1[7:0];
      default: begin
        for (i = m_vstart; i < m_vl; i++) begin
          case (op)
            OP_VADD_VV: write_elem(rd, i, read_elem(vs2, i) + read_elem(vs1, i));
            OP_VADD_VX: write_elem(rd, i, read_elem(vs2, i) + rs1);
            OP_VMV_VX:  write_elem(rd, i, rs1);
            default: ;
          endcase
        end
        data     = sign_ext(read_elem(vs2, 0));
        m_vstart = 0;
      end
    endcase
  end
  if (wb) begin
    exp_res.push_back({id, rd, data});
  end
endtask

`endif

/* verification/tb_vec_top.sv */
//////////////////////////////////////////////////
// Testbench of the vector slice. Offers random
// instructions and checks every response and
// result against the reference model
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_vec_top
  import vec_pkg::*;
();

  localparam int CLK_PERIOD    = 4;
  localparam int N_INSTR       = 400;
  localparam int CYC_PER_INSTR = 40;
  localparam int DRAIN_CYCLES  = 300;

  logic          clk_i;
  logic          rst_ni;
  logic          x_issue_valid_i;
  logic          x_issue_ready_o;
  x_issue_req_t  x_issue_req_i;
  logic          x_issue_resp_valid_o;
  x_issue_resp_t x_issue_resp_o;
  logic          x_result_valid_o;
  x_result_t     x_result_o;
  logic [3:0]    next_id;
  logic          take_seen;

  `include "vec_model.svh"

  vec_top vec_top_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .x_issue_valid_i     (x_issue_valid_i),
    .x_issue_ready_o     (x_issue_ready_o),
    .x_issue_req_i       (x_issue_req_i),
    .x_issue_resp_valid_o(x_issue_resp_valid_o),
    .x_issue_resp_o      (x_issue_resp_o),
    .x_result_valid_o    (x_result_valid_o),
    .x_result_o          (x_result_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("Fail %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  function automatic logic [31:0] encode(input logic [3:0] op, input logic [1:0] csr,
                                         input logic [5:0] hi, input logic [4:0] vs1,
                                         input logic [4:0] rd);
    return {op, csr, hi, vs1, 3'b000, rd, `VEC_MAJOR};
  endfunction

  // Called just after a rising edge
  // Returns just after the edge that took the offer
  task automatic offer(input logic [31:0] instr, input logic [31:0] rs1);
    x_issue_valid_i = 1'b1;
    x_issue_req_i   = '{instr: instr, rs1: rs1, rs2: $urandom(), id: next_id};
    @(negedge clk_i);
    while (!x_issue_ready_o) begin
      @(negedge clk_i);
    end
    model_take(instr, rs1, next_id);
    next_id = next_id + 4'd1;
    @(posedge clk_i);
    #1;
    x_issue_valid_i = 1'b0;
  endtask

  task automatic random_instr(output logic [31:0] instr, output logic [31:0] rs1);
    int unsigned sel;
    logic [1:0]  sew;
    logic [2:0]  lmul;
    logic [4:0]  vd, va, vb, rd;
    sel = $urandom_range(99, 0);
    vd  = 5'($urandom_range(7, 0));
    va  = 5'($urandom_range(7, 0));
    vb  = 5'($urandom_range(7, 0));
    rd  = 5'($urandom_range(31, 0));
    rs1 = $urandom();
    if (sel < 16) begin
      sew  = 2'($urandom_range(2, 0));
      lmul = 3'($urandom_range(7, 0));
      // Mostly legal vtypes with a few reserved ones
      if ($urandom_range(3, 0) == 0) begin
        sew = 2'($urandom_range(3, 0));
      end else if (lmul == LMUL_RES || lmul == LMUL_F8) begin
        lmul = LMUL_1;
      end
      // x0 AVL gives VLMAX or keeps vl together with x0 rd
      va = ($urandom_range(2, 0) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
      rd = ($urandom_range(3, 0) == 0) ? 5'd0 : rd;
      rs1 = ($urandom_range(3, 0) != 0) ? $urandom_range(40, 0) : rs1;
      instr = encode(OP_VSETVL, 2'b00, {1'b0, sew, lmul}, va, rd);
    end else if (sel < 28) begin
      instr = encode(OP_CSRR, 2'($urandom_range(3, 0)), '0, '0, rd);
    end else if (sel < 34) begin
      rs1   = $urandom_range(10, 0);
      instr = encode(OP_CSRW_VSTART, '0, '0, '0, '0);
    end else if (sel < 48) begin
      instr = encode(OP_VMV_VX, '0, '0, va, vd);
    end else if (sel < 62) begin
      instr = encode(OP_VADD_VV, '0, {1'b0, vb}, va, vd);
    end else if (sel < 74) begin
      instr = encode(OP_VADD_VX, '0, {1'b0, vb}, va, vd);
    end else if (sel < 88) begin
      instr = encode(OP_VMV_XS, '0, {1'b0, vb}, '0, rd);
    end else begin
      case ($urandom_range(2, 0))
        // Wrong major opcode
        0: instr = encode(OP_VADD_VV, '0, {1'b0, vb}, va, vd) ^ 32'($urandom_range(127, 1));
        1: instr = encode(4'($urandom_range(15, 7)), '0, '0, '0, rd);
        default: instr = encode(OP_VMV_VX, '0, '0, '0, 5'($urandom_range(31, 8)));
      endcase
    end
  endtask

  //////////////////////////////////////////////////
  // Output checks
  //////////////////////////////////////////////////

  task automatic check_outputs();
    logic [5:0]  rsp;
    logic [40:0] res;
    int          hit;
    hit = -1;
    // Response exactly one cycle after each take
    check_val("x_issue_resp_valid_o", x_issue_resp_valid_o, take_seen);
    if (x_issue_resp_valid_o) begin
      rsp = exp_resp.pop_front();
      check_val("x_issue_resp_o.id", x_issue_resp_o.id, rsp[5:2]);
      check_val("x_issue_resp_o.accept", x_issue_resp_o.accept, rsp[1]);
      check_val("x_issue_resp_o.writeback", x_issue_resp_o.writeback, rsp[0]);
    end
    if (x_result_valid_o) begin
      foreach (exp_res[i]) begin
        if (hit < 0 && exp_res[i][40:37] == x_result_o.id) begin
          hit = i;
        end
      end
      if (hit < 0) begin
        stop_run($sformatf("Result with id %0h that no accepted instruction expects",
                           x_result_o.id));
      end else begin
        res = exp_res[hit];
        exp_res.delete(hit);
        check_val("x_result_o.rd", x_result_o.rd, res[36:32]);
        check_val("x_result_o.data", x_result_o.data, res[31:0]);
      end
    end
    take_seen = x_issue_valid_i & x_issue_ready_o;
  endtask

  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_outputs();
    end
  end

  initial begin
    #(N_INSTR * CYC_PER_INSTR * CLK_PERIOD);
    stop_run("Timeout: the instruction stream did not complete in time");
  end

  initial begin
    logic [31:0] instr, rs1;
    int unsigned n, wait_cyc;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    x_issue_valid_i = 1'b0;
    x_issue_req_i   = '0;
    next_id         = '0;
    take_seen       = 1'b0;
    void'($urandom(32'hc9e8));
    model_reset();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("x_issue_ready_o", x_issue_ready_o, 1'b1);
    check_val("x_result_valid_o", x_result_valid_o, 1'b0);
    @(posedge clk_i);
    #1;

    // Reset values of vtype and vl
    offer(encode(OP_CSRR, CSR_VTYPE, '0, '0, 5'd1), '0);
    offer(encode(OP_CSRR, CSR_VL, '0, '0, 5'd2), '0);
    // vmv.x.s behind a busy unit and then a read burst that meets its result
    offer(encode(OP_VSETVL, '0, {1'b0, SEW_32, LMUL_1}, '0, 5'd3), '0);
    offer(encode(OP_VMV_VX, '0, '0, '0, 5'd4), 32'h8000_1234);
    offer(encode(OP_VMV_XS, '0, 6'd4, '0, 5'd5), '0);
    // The unit is still busy with vmv.v.x, so vmv.x.s waits in the buffer
    @(negedge clk_i);
    check_val("x_issue_ready_o", x_issue_ready_o, 1'b0);
    @(posedge clk_i);
    #1;
    repeat (8) begin
      offer(encode(OP_CSRR, CSR_VL, '0, '0, 5'd6), '0);
    end

    for (n = 13; n < N_INSTR; n++) begin
      random_instr(instr, rs1);
      offer(instr, rs1);
      if ($urandom_range(3, 0) == 0) begin
        repeat ($urandom_range(3, 1)) begin
          @(posedge clk_i);
          #1;
        end
      end
    end

    wait_cyc = 0;
    while ((exp_res.size() != 0 || exp_resp.size() != 0) && wait_cyc < DRAIN_CYCLES) begin
      @(posedge clk_i);
      wait_cyc++;
    end
    repeat (4) @(negedge clk_i);
    if (exp_res.size() != 0 || exp_resp.size() != 0) begin
      stop_run("Responses or results still missing after the last instruction");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

/* source/vec_top.sv */
//////////////////////////////////////////////////
// Vector slice top level. Connects decoder,
// controller and functional unit to the core
//////////////////////////////////////////////////

`timescale 1ns/10ps

module vec_top
  import vec_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          x_issue_valid_i,
  output logic          x_issue_ready_o,
  input  x_issue_req_t  x_issue_req_i,
  output logic          x_issue_resp_valid_o,
  output x_issue_resp_t x_issue_resp_o,
  output logic          x_result_valid_o,
  output x_result_t     x_result_o
);

  logic     issue_take;
  logic     dec_valid, dec_illegal;
  vec_req_t dec_req, unit_req;
  logic     unit_req_valid, unit_ready, unit_rsp_valid;
  vec_rsp_t unit_rsp;

  // Offer is taken when valid meets ready
  assign issue_take = x_issue_valid_i & x_issue_ready_o;

  vec_decoder vec_decoder_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid_i(issue_take),
    .issue_req_i  (x_issue_req_i),
    .dec_valid_o  (dec_valid),
    .dec_req_o    (dec_req),
    .dec_illegal_o(dec_illegal)
  );

  vec_controller vec_controller_i (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .dec_valid_i         (dec_valid),
    .dec_req_i           (dec_req),
    .dec_illegal_i       (dec_illegal),
    .x_issue_ready_o     (x_issue_ready_o),
    .x_issue_resp_valid_o(x_issue_resp_valid_o),
    .x_issue_resp_o      (x_issue_resp_o),
    .unit_req_valid_o    (unit_req_valid),
    .unit_req_o          (unit_req),
    .unit_ready_i        (unit_ready),
    .unit_rsp_valid_i    (unit_rsp_valid),
    .unit_rsp_i          (unit_rsp),
    .x_result_valid_o    (x_result_valid_o),
    .x_result_o          (x_result_o)
  );

  vec_unit vec_unit_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid_i(unit_req_valid),
    .req_i      (unit_req),
    .ready_o    (unit_ready),
    .rsp_valid_o(unit_rsp_valid),
    .rsp_o      (unit_rsp)
  );

endmodule

/* source/vec_unit.sv */
//////////////////////////////////////////////////
// Vector functional unit. Owns the register file
// and walks one element per cycle from vstart to vl
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "vec_defs.svh"

module vec_unit
  import vec_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  vec_req_t req_i,
  output logic     ready_o,
  output logic     rsp_valid_o,
  output vec_rsp_t rsp_o
);

  localparam int unsigned VRF_BYTES = `VEC_VLENB * `VEC_NRVREG;
  localparam int unsigned AW        = $clog2(VRF_BYTES);
  localparam int unsigned EBYTES    = `VEC_ELEN / 8;

  typedef enum logic [1:0] {IDLE, RUN, DONE} state_e;

  state_e        state_q;
  vec_req_t      req_q;
  vlen_t         idx_q;
  logic [7:0]    vrf_q [VRF_BYTES];
  logic [AW-1:0] addr_d;
  elen_t         elem_s1, elem_s2, elem_0, wdata;
  logic          we;
  vec_sew_e      sew;

  // Register groups wrap around the end of the register file
  function automatic logic [AW-1:0] elem_addr(input reg_idx_t vreg, input vlen_t idx,
                                              input vec_sew_e esew);
    return AW'(vreg * `VEC_VLENB + (idx << esew));
  endfunction

  function automatic elen_t read_elem(input logic [AW-1:0] addr, input vec_sew_e esew);
    elen_t e;
    e = '0;
    for (int b = 0; b < EBYTES; b++) begin
      if (b < (1 << esew)) begin
        e[8*b +: 8] = vrf_q[AW'(addr + AW'(b))];
      end
    end
    return e;
  endfunction

  assign sew     = req_q.vtype.vsew;
  assign addr_d  = elem_addr(req_q.vd, idx_q, sew);
  assign ready_o = (state_q == IDLE);

  always_comb begin
    elem_s1 = read_elem(elem_addr(req_q.vs1, idx_q, sew), sew);
    elem_s2 = read_elem(elem_addr(req_q.vs2, idx_q, sew), sew);
    elem_0  = read_elem(elem_addr(req_q.vs2, '0, sew), sew);
    we      = 1'b0;
    wdata   = '0;
    if (state_q == RUN) begin
      case (req_q.op)
        OP_VADD_VV: begin
          we    = 1'b1;
          wdata = elem_s2 + elem_s1;
        end
        OP_VADD_VX: begin
          we    = 1'b1;
          wdata = elem_s2 + req_q.rs1;
        end
        OP_VMV_VX: begin
          we    = 1'b1;
          wdata = req_q.rs1;
        end
        default: ;
      endcase
    end
  end

  // Completion record, vmv.x.s returns element 0 sign-extended
  always_comb begin
    rsp_o           = '0;
    rsp_o.id        = req_q.id;
    rsp_o.rd        = req_q.rd;
    rsp_o.writeback = req_q.use_rd;
    if (req_q.op == OP_VMV_XS) begin
      case (sew)
        SEW_8:   rsp_o.data = {{24{elem_0[7]}}, elem_0[7:0]};
        SEW_16:  rsp_o.data = {{16{elem_0[15]}}, elem_0[15:0]};
        default: rsp_o.data = elem_0;
      endcase
    end
  end

  assign rsp_valid_o = (state_q == DONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
      for (int i = 0; i < VRF_BYTES; i++) begin
        vrf_q[i] <= '0;
      end
    end else begin
      if (we) begin
        for (int b = 0; b < EBYTES; b++) begin
          if (b < (1 << sew)) begin
            vrf_q[AW'(addr_d + AW'(b))] <= wdata[8*b +: 8];
          end
        end
      end
      case (state_q)
        IDLE: begin
          if (req_valid_i) begin
            idx_q   <= req_i.vstart;
            // Empty body when vstart has reached vl
            state_q <= (req_i.vstart < req_i.vl) ? RUN : DONE;
          end
        end
        RUN: begin
          idx_q <= idx_q + 1'b1;
          if (vlen_t'(idx_q + 1'b1) == req_q.vl) begin
            state_q <= DONE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && req_valid_i) begin
      req_q <= req_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) req_valid_i |-> state_q == IDLE)
    else $error("request offered while the unit is busy");

endmodule

/* source/vec_controller.sv */
//////////////////////////////////////////////////
// Vector CSRs, vl computation and the one-entry
// request buffer. Answers every decoded offer and
// merges CSR retirements with unit results
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "vec_defs.svh"

module vec_controller
  import vec_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  // Decoded offer
  input  logic          dec_valid_i,
  input  vec_req_t      dec_req_i,
  input  logic          dec_illegal_i,
  // Core issue side
  output logic          x_issue_ready_o,
  output logic          x_issue_resp_valid_o,
  output x_issue_resp_t x_issue_resp_o,
  // Functional unit
  output logic          unit_req_valid_o,
  output vec_req_t      unit_req_o,
  input  logic          unit_ready_i,
  input  logic          unit_rsp_valid_i,
  input  vec_rsp_t      unit_rsp_i,
  // Core result side
  output logic          x_result_valid_o,
  output x_result_t     x_result_o
);

  localparam vtype_t VTYPE_VILL = '{vill: 1'b1, vsew: SEW_8, vlmul: LMUL_1};

  function automatic vlen_t calc_vlmax(input vtype_t vt);
    vlen_t vlmax;
    vlmax = vlen_t'(`VEC_VLENB) >> vt.vsew;
    case (vt.vlmul)
      LMUL_2:  vlmax = vlmax << 1;
      LMUL_4:  vlmax = vlmax << 2;
      LMUL_8:  vlmax = vlmax << 3;
      LMUL_F2: vlmax = vlmax >> 1;
      LMUL_F4: vlmax = vlmax >> 2;
      default: ;
    endcase
    return vlmax;
  endfunction

  // Reserved encodings, or SEW above 32 times the fraction
  function automatic logic vtype_bad(input vtype_t vt);
    return (vt.vsew == SEW_RES) || (vt.vlmul == LMUL_RES) || (vt.vlmul == LMUL_F8)
        || ((vt.vlmul == LMUL_F2) && (vt.vsew == SEW_32))
        || ((vt.vlmul == LMUL_F4) && (vt.vsew != SEW_8));
  endfunction

  // log2 of SEW/LMUL relative to SEW 8
  function automatic int sew_lmul_ratio(input vtype_t vt);
    logic signed [2:0] lmul_s;
    lmul_s = vt.vlmul;
    return int'(vt.vsew) - int'(lmul_s);
  endfunction

  vlen_t     vstart_q, vstart_d;
  vlen_t     vl_q, vl_d;
  vtype_t    vtype_q, vtype_d;
  vec_req_t  buf_q, cur_req;
  logic      buf_full_q;
  x_result_t res_q, con_result;
  logic      res_valid_q;
  logic      accept, dec_go, dec_stall, buf_stall, buf_go, buf_load, cur_go;
  logic      con_retire;
  vlen_t     new_vlmax;

  //////////////////////////////////////////////////
  // Accept, issue or hold
  //////////////////////////////////////////////////

  assign accept = ~dec_illegal_i & ~((dec_req_i.ex_unit == VFU) & vtype_q.vill);
  assign dec_go = dec_valid_i & accept;

  // A unit request waits for the unit, a CSR retirement for the result port
  assign dec_stall = (dec_req_i.ex_unit == VFU) ? ~unit_ready_i : res_valid_q;
  assign buf_stall = (buf_q.ex_unit == VFU) ? ~unit_ready_i : res_valid_q;
  assign buf_load  = dec_go & dec_stall;
  assign buf_go    = buf_full_q & ~buf_stall;
  assign cur_go    = buf_go | (dec_go & ~dec_stall);
  assign cur_req   = buf_full_q ? buf_q : dec_req_i;

  assign con_retire       = cur_go & (cur_req.ex_unit == CON);
  assign unit_req_valid_o = cur_go & (cur_req.ex_unit == VFU);
  assign x_issue_ready_o  = ~buf_full_q & ~buf_load;

  assign x_issue_resp_valid_o = dec_valid_i;
  assign x_issue_resp_o = '{id: dec_req_i.id, accept: accept,
                            writeback: accept & dec_req_i.use_rd};

  always_comb begin
    unit_req_o        = cur_req;
    unit_req_o.vl     = vl_q;
    unit_req_o.vstart = vstart_q;
    unit_req_o.vtype  = vtype_q;
  end

  //////////////////////////////////////////////////
  // CSR update
  //////////////////////////////////////////////////

  assign new_vlmax = calc_vlmax(cur_req.vtype_new);

  always_comb begin
    vstart_d = vstart_q;
    vl_d     = vl_q;
    vtype_d  = vtype_q;
    if (unit_req_valid_o) begin
      vstart_d = '0;
    end
    if (con_retire && (cur_req.op == OP_CSRW_VSTART)) begin
      vstart_d = vlen_t'(cur_req.rs1);
    end
    if (con_retire && (cur_req.op == OP_VSETVL)) begin
      vtype_d = '{vill: 1'b0, vsew: cur_req.vtype_new.vsew, vlmul: cur_req.vtype_new.vlmul};
      if (vtype_bad(cur_req.vtype_new)) begin
        vtype_d = VTYPE_VILL;
        vl_d    = '0;
      end else if (cur_req.keep_vl) begin
        // Keeping vl is only legal at the same SEW/LMUL ratio
        if (sew_lmul_ratio(cur_req.vtype_new) != sew_lmul_ratio(vtype_q)) begin
          vtype_d = VTYPE_VILL;
          vl_d    = '0;
        end
      end else if (cur_req.vs1 == '0) begin
        vl_d = new_vlmax;
      end else begin
        vl_d = (cur_req.rs1 < elen_t'(new_vlmax)) ? vlen_t'(cur_req.rs1) : new_vlmax;
      end
    end
  end

  //////////////////////////////////////////////////
  // Results
  //////////////////////////////////////////////////

  always_comb begin
    con_result    = '0;
    con_result.id = cur_req.id;
    con_result.rd = cur_req.rd;
    if (cur_req.op == OP_VSETVL) begin
      con_result.data = elen_t'(vl_d);
    end else begin
      case (cur_req.csr)
        CSR_VSTART: con_result.data = elen_t'(vstart_q);
        CSR_VL:     con_result.data = elen_t'(vl_q);
        CSR_VTYPE:  con_result.data = elen_t'(vtype_q);
        default:    con_result.data = elen_t'(`VEC_VLENB);
      endcase
    end
  end

  // Registered unit result has priority, a colliding retirement waits in the buffer
  assign x_result_valid_o = res_valid_q | (con_retire & cur_req.use_rd);
  assign x_result_o       = res_valid_q ? res_q : con_result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vstart_q    <= '0;
      vl_q        <= '0;
      vtype_q     <= VTYPE_VILL;
      buf_full_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      vstart_q    <= vstart_d;
      vl_q        <= vl_d;
      vtype_q     <= vtype_d;
      buf_full_q  <= buf_load | (buf_full_q & ~buf_go);
      res_valid_q <= unit_rsp_valid_i & unit_rsp_i.writeback;
    end
  end

  always_ff @(posedge clk_i) begin
    if (buf_load) begin
      buf_q <= dec_req_i;
    end
    if (unit_rsp_valid_i) begin
      res_q <= '{id: unit_rsp_i.id, rd: unit_rsp_i.rd, data: unit_rsp_i.data};
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) unit_req_valid_o |-> unit_ready_i)
    else $error("unit request issued while the unit is busy");

  assert property (@(posedge clk_i) disable iff (!rst_ni) buf_load |-> !buf_full_q)
    else $error("request buffer loaded while full");

endmodule

/* source/vec_decoder.sv */
//////////////////////////////////////////////////
// Instruction decoder. Registers each taken offer
// and presents the decoded request one cycle later
//////////////////////////////////////////////////

`timescale 1ns/10ps

`include "vec_defs.svh"

module vec_decoder
  import vec_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         issue_valid_i,
  input  x_issue_req_t issue_req_i,
  output logic         dec_valid_o,
  output vec_req_t     dec_req_o,
  output logic         dec_illegal_o
);

  logic         valid_q;
  x_issue_req_t req_q;
  logic [31:0]  instr;
  logic         bad_reg;

  // True for an index past the register file
  function automatic logic out_of_range(input reg_idx_t idx);
    return idx >= reg_idx_t'(`VEC_NRVREG);
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      req_q <= issue_req_i;
    end
  end

  assign instr = req_q.instr;

  always_comb begin
    dec_req_o           = '0;
    dec_req_o.op        = vec_op_e'(instr[31:28]);
    dec_req_o.ex_unit   = CON;
    dec_req_o.vd        = instr[11:7];
    dec_req_o.rd        = instr[11:7];
    dec_req_o.vs1       = instr[19:15];
    dec_req_o.vs2       = instr[24:20];
    dec_req_o.rs1       = req_q.rs1;
    dec_req_o.rs2       = req_q.rs2;
    dec_req_o.csr       = vec_csr_e'(instr[27:26]);
    dec_req_o.vtype_new = vtype_t'(instr[25:20]);
    dec_req_o.id        = req_q.id;
    bad_reg             = 1'b0;

    unique case (instr[31:28])
      OP_VSETVL: begin
        dec_req_o.use_rd  = 1'b1;
        // x0 source and x0 destination keep the current vl
        dec_req_o.keep_vl = (instr[19:15] == '0) && (instr[11:7] == '0);
      end
      OP_CSRR: dec_req_o.use_rd = 1'b1;
      OP_CSRW_VSTART: ;
      OP_VADD_VV: begin
        dec_req_o.ex_unit = VFU;
        bad_reg = out_of_range(instr[11:7]) | out_of_range(instr[19:15])
                | out_of_range(instr[24:20]);
      end
      OP_VADD_VX: begin
        dec_req_o.ex_unit = VFU;
        bad_reg = out_of_range(instr[11:7]) | out_of_range(instr[24:20]);
      end
      OP_VMV_VX: begin
        dec_req_o.ex_unit = VFU;
        bad_reg = out_of_range(instr[11:7]);
      end
      OP_VMV_XS: begin
        dec_req_o.ex_unit = VFU;
        dec_req_o.use_rd  = 1'b1;
        bad_reg = out_of_range(instr[24:20]);
      end
      default: bad_reg = 1'b1;
    endcase
  end

  assign dec_valid_o   = valid_q;
  assign dec_illegal_o = (instr[6:0] != `VEC_MAJOR) | bad_reg;

endmodule

/* source/vec_pkg.sv */
//////////////////////////////////////////////////
// Shared types of the vector slice: opcodes, vtype
// fields, the decoded request and the core-facing
// issue, response and result records
//////////////////////////////////////////////////

`include "vec_defs.svh"

package vec_pkg;

  // vl and vstart hold up to VLENB * 8 elements
  typedef logic [$clog2(`VEC_VLENB * 8 + 1)-1:0] vlen_t;
  typedef logic [`VEC_ELEN-1:0] elen_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [3:0] id_t;

  // Instruction bits 31:28
  typedef enum logic [3:0] {
    OP_VSETVL      = 4'd0,
    OP_CSRR        = 4'd1,
    OP_CSRW_VSTART = 4'd2,
    OP_VADD_VV     = 4'd3,
    OP_VADD_VX     = 4'd4,
    OP_VMV_VX      = 4'd5,
    OP_VMV_XS      = 4'd6
  } vec_op_e;

  typedef enum logic [1:0] {SEW_8, SEW_16, SEW_32, SEW_RES} vec_sew_e;

  // Signed order, the fractions come last
  typedef enum logic [2:0] {
    LMUL_1, LMUL_2, LMUL_4, LMUL_8, LMUL_RES, LMUL_F8, LMUL_F4, LMUL_F2
  } vec_lmul_e;

  // Instruction bits 27:26
  typedef enum logic [1:0] {CSR_VSTART, CSR_VL, CSR_VTYPE, CSR_VLENB} vec_csr_e;

  typedef enum logic {CON, VFU} vec_unit_e;

  typedef struct packed {
    logic      vill;
    vec_sew_e  vsew;
    vec_lmul_e vlmul;
  } vtype_t;

  typedef struct packed {
    vec_op_e   op;
    vec_unit_e ex_unit;
    reg_idx_t  vd;
    reg_idx_t  vs1;
    reg_idx_t  vs2;
    reg_idx_t  rd;
    elen_t     rs1;
    elen_t     rs2;
    vec_csr_e  csr;
    logic      use_rd;
    logic      keep_vl;
    vtype_t    vtype_new;
    id_t       id;
    // Stamped by the controller at issue
    vlen_t     vl;
    vlen_t     vstart;
    vtype_t    vtype;
  } vec_req_t;

  typedef struct packed {
    logic [31:0] instr;
    elen_t       rs1;
    elen_t       rs2;
    id_t         id;
  } x_issue_req_t;

  typedef struct packed {
    id_t  id;
    logic accept;
    logic writeback;
  } x_issue_resp_t;

  typedef struct packed {
    id_t      id;
    reg_idx_t rd;
    elen_t    data;
  } x_result_t;

  typedef struct packed {
    id_t      id;
    reg_idx_t rd;
    elen_t    data;
    logic     writeback;
  } vec_rsp_t;

endpackage

/* source/vec_defs.svh */
//////////////////////////////////////////////////
// Sizing constants and the major opcode of the
// vector slice, included wherever they are used
//////////////////////////////////////////////////

`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Vector register length in bits
`define VEC_VLEN 128

// Same length in bytes
`define VEC_VLENB (`VEC_VLEN / 8)

// Architectural vector registers
`define VEC_NRVREG 8

// Widest element, also the scalar operand width
`define VEC_ELEN 32

// OP-V major opcode
`define VEC_MAJOR 7'b1010111

`endif
